//--- Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= dataCache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- dataCache.f
src/dataCachePkg.sv
src/requestLatch.sv
src/cacheArray.sv
src/responseStage.sv
src/missControl.sv
src/dataCache.sv
sim/dataCache_assertions.sv
sim/dataCacheTb.sv

//--- sim/dataCacheTb.sv
`timescale 1ns/1ns
`default_nettype none

module dataCacheTb;

  import dataCachePkg::*;

  localparam int TESTS           = 5;
  localparam int CYCLES_PER_TEST = 400;

  logic      clkIn;
  logic      resetIn;
  accessT    accessType;
  logic      readWriteIn;
  wordT      dataAddrIn;
  wordT      dataIn;
  logic      dataOutValid;
  wordT      dataOut;
  logic      dataWriteSuc;
  logic      memDataValid;
  blockAddrT memAddr;
  lineT      memDataIn;
  logic      acceptWrite;
  logic      miss;
  blockAddrT missAddr;
  logic      readWriteOut;
  blockAddrT memAddrOut;
  lineT      memOut;

  logic [7:0]       refBytes [wordT]; // what loads must return
  logic [7:0]       memBytes [wordT]; // backing memory
  logic [LINES-1:0] lineValid = '0;
  logic [LINES-1:0] lineDirty = '0;
  blockAddrT        lineBlock [LINES];
  blockAddrT        wantedBlock;
  blockAddrT        victimBlock;
  int               errors = 0;
  int               offers = 0;
  int               fetches = 0;
  int               testsRun = 0;

  dataCache uut (.*);

  initial begin
    clkIn = 1'b0;
    forever #4 clkIn = ~clkIn;
  end

  function automatic logic [7:0] initialByte(input wordT a);
    return 8'(a * 7 + 3);
  endfunction

  function automatic logic [7:0] refByte(input wordT a);
    return refBytes.exists(a) ? refBytes[a] : initialByte(a);
  endfunction

  function automatic lineT refLine(input blockAddrT b);
    lineT l;
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      l[8*i +: 8] = refByte({b, BLOCK_WIDTH'(i)});
    end
    return l;
  endfunction

  function automatic int accessBytes(input accessT kind);
    return (kind == ACCESS_BYTE) ? 1 : (kind == ACCESS_HALF) ? 2 : 4;
  endfunction

  task automatic compareValue(input string what, input lineT got, input lineT expected);
    assert (got == expected) else begin
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic access(input logic rd, input accessT kind, input wordT addr, input wordT wdata);
    int    cycles;
    int    offersBefore;
    int    fetchesBefore;
    int    n;
    logic  hitExpected;
    logic  wbExpected;
    wordT  expected;
    indexT idx;
    idx           = addr[BLOCK_WIDTH +: INDEX_WIDTH];
    n             = accessBytes(kind);
    hitExpected   = lineValid[idx] && (lineBlock[idx] == addr[31:BLOCK_WIDTH]);
    wbExpected    = !hitExpected && lineValid[idx] && lineDirty[idx];
    victimBlock   = lineBlock[idx];
    wantedBlock   = addr[31:BLOCK_WIDTH];
    offersBefore  = offers;
    fetchesBefore = fetches;
    @(negedge clkIn);
    accessType  = kind;
    readWriteIn = rd;
    dataAddrIn  = addr;
    dataIn      = wdata;
    @(negedge clkIn);
    accessType = ACCESS_NONE; // one-cycle strobe
    cycles     = 1;
    while (!dataOutValid && !dataWriteSuc) begin
      @(negedge clkIn);
      cycles++;
    end
    compareValue("load response", lineT'(dataOutValid), lineT'(rd));
    if (hitExpected) begin
      compareValue("hit latency", lineT'(cycles), lineT'(2));
    end
    compareValue("write-back offers", lineT'(offers - offersBefore), lineT'(wbExpected));
    compareValue("block requests", lineT'(fetches - fetchesBefore), lineT'(!hitExpected));
    if (!hitExpected) begin
      lineValid[idx] = 1'b1;
      lineDirty[idx] = 1'b0; // refill lands clean
      lineBlock[idx] = addr[31:BLOCK_WIDTH];
    end
    if (rd) begin
      expected = '0;
      for (int i = 0; i < n; i++) begin
        expected |= wordT'(refByte(addr + wordT'(i))) << (8 * i);
      end
      compareValue("load data", lineT'(dataOut), lineT'(expected));
    end else begin
      for (int i = 0; i < n; i++) begin
        refBytes[addr + wordT'(i)] = wdata[8*i +: 8];
      end
      lineDirty[idx] = 1'b1;
    end
  endtask

  task automatic endTest(input string name, input int errorsBefore);
    testsRun++;
    if (errors == errorsBefore) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d check(s) failed", name, errors - errorsBefore);
    end
  endtask

  // answers write-back offers and block requests after random delays
  initial begin : memoryModel
    int   delay;
    wordT a;
    memDataValid = 1'b0;
    memAddr      = '0;
    memDataIn    = '0;
    acceptWrite  = 1'b0;
    forever begin
      @(negedge clkIn);
      if (!resetIn && !readWriteOut) begin
        offers++;
        compareValue("write-back address", lineT'(memAddrOut), lineT'(victimBlock));
        compareValue("write-back data", memOut, refLine(victimBlock));
        delay = int'($urandom_range(8, 1));
        repeat (delay) @(negedge clkIn);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          memBytes[{memAddrOut, BLOCK_WIDTH'(i)}] = memOut[8*i +: 8];
        end
        acceptWrite = 1'b1;
        @(negedge clkIn);
        acceptWrite = 1'b0;
      end else if (!resetIn && miss) begin
        fetches++;
        compareValue("miss address", lineT'(missAddr), lineT'(wantedBlock));
        delay = int'($urandom_range(8, 1));
        repeat (delay) @(negedge clkIn);
        memAddr = missAddr;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          a = {missAddr, BLOCK_WIDTH'(i)};
          memDataIn[8*i +: 8] = memBytes.exists(a) ? memBytes[a] : initialByte(a);
        end
        memDataValid = 1'b1;
        @(negedge clkIn);
        memDataValid = 1'b0;
      end
    end
  end

  initial begin : stimulus
    int     mark;
    wordT   addr;
    accessT kind;
    void'($urandom(39012));
    resetIn     = 1'b1;
    accessType  = ACCESS_NONE;
    readWriteIn = 1'b1;
    dataAddrIn  = '0;
    dataIn      = '0;
    repeat (10) @(negedge clkIn);
    resetIn = 1'b0;

    mark = errors;
    compareValue("miss after reset", lineT'(miss), '0);
    compareValue("dataOutValid after reset", lineT'(dataOutValid), '0);
    compareValue("dataWriteSuc after reset", lineT'(dataWriteSuc), '0);
    compareValue("readWriteOut after reset", lineT'(readWriteOut), lineT'(1));
    access(1'b1, ACCESS_WORD, 32'h0000_1230, '0);
    endTest("reset", mark);

    mark = errors;
    repeat (24) begin
      kind = accessT'($urandom_range(3, 1));
      addr = 32'h0000_1000 | wordT'($urandom_range(127, 0));
      addr = addr & ~wordT'(accessBytes(kind) - 1); // aligned offsets only
      access(1'b1, kind, addr, '0);
    end
    endTest("read after refill", mark);

    mark = errors;
    access(1'b1, ACCESS_WORD, 32'h0000_1050, '0);
    access(1'b0, ACCESS_BYTE, 32'h0000_1053, 32'h0000_00a5);
    access(1'b0, ACCESS_HALF, 32'h0000_1056, 32'h0000_c3d2);
    access(1'b0, ACCESS_WORD, 32'h0000_1058, 32'h1234_5678);
    for (int i = 0; i < 4; i++) begin
      access(1'b1, ACCESS_WORD, 32'h0000_1050 + wordT'(4 * i), '0); // neighbours too
    end
    access(1'b1, ACCESS_BYTE, 32'h0000_1053, '0);
    endTest("write hits", mark);

    mark = errors;
    access(1'b0, ACCESS_WORD, 32'h0000_2040, 32'hdead_beef);
    access(1'b1, ACCESS_HALF, 32'h0000_3042, '0); // same index, new tag
    access(1'b1, ACCESS_WORD, 32'h0000_2040, '0);
    access(1'b1, ACCESS_BYTE, 32'h0000_3051, '0);
    endTest("dirty eviction", mark);

    mark = errors;
    access(1'b1, ACCESS_WORD, 32'h0000_4080, '0);
    access(1'b1, ACCESS_WORD, 32'h0000_5080, '0);
    access(1'b1, ACCESS_BYTE, 32'h0000_4083, '0);
    endTest("clean eviction", mark);

    $display("tests run %0d, check failures %0d, assertion failures %0d",
             testsRun, errors, uut.checks.failures);
    if (errors == 0 && uut.checks.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TESTS * CYCLES_PER_TEST) @(posedge clkIn);
    $display("watchdog expired after %0d cycles, the tests did not complete",
             TESTS * CYCLES_PER_TEST);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/dataCache_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module dataCacheAssertions (
  input logic clkIn,
  input logic resetIn,
  input logic dataOutValid,
  input logic dataWriteSuc,
  input logic miss,
  input logic readWriteOut,
  input logic memDataValid
);

  int failures = 0;

  pulsesExclusive: assert property (@(posedge clkIn) disable iff (resetIn)
    !(dataOutValid && dataWriteSuc))
    else begin $error("load and store responses high together"); failures++; end

  loadPulseShort: assert property (@(posedge clkIn) disable iff (resetIn)
    dataOutValid |=> !dataOutValid)
    else begin $error("dataOutValid longer than one cycle"); failures++; end

  storePulseShort: assert property (@(posedge clkIn) disable iff (resetIn)
    dataWriteSuc |=> !dataWriteSuc)
    else begin $error("dataWriteSuc longer than one cycle"); failures++; end

  noResponseInMiss: assert property (@(posedge clkIn) disable iff (resetIn)
    !((dataOutValid || dataWriteSuc) && miss))
    else begin $error("response pulse while miss is high"); failures++; end

  // victim goes out before the block is asked for
  offerBeforeFetch: assert property (@(posedge clkIn) disable iff (resetIn)
    !readWriteOut |-> !miss)
    else begin $error("miss raised during a write-back offer"); failures++; end

  missHeld: assert property (@(posedge clkIn) disable iff (resetIn)
    (miss && !memDataValid) |=> miss)
    else begin $error("miss dropped before the block arrived"); failures++; end

  resetState: assert property (@(posedge clkIn)
    resetIn |=> (!miss && readWriteOut && !dataOutValid && !dataWriteSuc))
    else begin $error("outputs wrong after reset"); failures++; end

endmodule

bind dataCache dataCacheAssertions checks (
  .clkIn, .resetIn, .dataOutValid, .dataWriteSuc, .miss, .readWriteOut,
  .memDataValid
);

`default_nettype wire

//--- src/cacheArray.sv
`timescale 1ns/1ns
`default_nettype none

module cacheArray (
  input  logic                    clkIn,
  input  logic                    resetIn,
  input  logic                    pending,
  input  dataCachePkg::accessT    reqAccess,
  input  logic                    reqRead,
  input  dataCachePkg::wordT      reqAddr,
  input  dataCachePkg::wordT      reqData,
  input  logic                    served,
  input  logic                    memDataValid,
  input  dataCachePkg::blockAddrT memAddr,
  input  dataCachePkg::lineT      memDataIn,
  input  logic                    cleanVictim,
  input  logic                    evictVictim,
  output logic                    hit,
  output dataCachePkg::lineT      hitLine,
  output logic                    victimDirty,
  output dataCachePkg::tagT       victimTag,
  output dataCachePkg::lineT      victimLine
);

  import dataCachePkg::*;

  logic [LINES-1:0] validBits;
  logic [LINES-1:0] dirtyBits;
  tagT              tagMem [LINES];
  lineT             dataMem [LINES];

  indexT  reqIndex;
  tagT    reqTag;
  offsetT reqOffset;
  indexT  memIndex;
  tagT    memTag;
  logic   storeEn;

  logic [BLOCK_BYTES-1:0] laneMask;
  lineT                   storeLine;
  lineT                   mergedLine;

  // address split of the held request
  assign reqOffset = reqAddr[BLOCK_WIDTH-1:0];
  assign reqIndex  = reqAddr[BLOCK_WIDTH +: INDEX_WIDTH];
  assign reqTag    = reqAddr[31 -: TAG_WIDTH];

  // refill block address
  assign memIndex = memAddr[INDEX_WIDTH-1:0];
  assign memTag   = memAddr[INDEX_WIDTH +: TAG_WIDTH];

  // no hit while the replacement block is on its way
  assign hit = pending && validBits[reqIndex] && (tagMem[reqIndex] == reqTag) && !evictVictim;

  assign hitLine     = dataMem[reqIndex];
  assign victimLine  = dataMem[reqIndex];
  assign victimTag   = tagMem[reqIndex];
  assign victimDirty = validBits[reqIndex] && dirtyBits[reqIndex];

  assign storeEn = served && !reqRead;

  // byte lanes touched by the store, offsets assumed aligned
  always_comb begin
    case (reqAccess)
      ACCESS_BYTE: laneMask = BLOCK_BYTES'(4'b0001) << reqOffset;
      ACCESS_HALF: laneMask = BLOCK_BYTES'(4'b0011) << reqOffset;
      ACCESS_WORD: laneMask = BLOCK_BYTES'(4'b1111) << reqOffset;
      default:     laneMask = '0;
    endcase
  end

  assign storeLine = lineT'(reqData) << {reqOffset, 3'b000};

  always_comb begin
    mergedLine = dataMem[reqIndex];
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      if (laneMask[i]) begin
        mergedLine[8*i +: 8] = storeLine[8*i +: 8];
      end
    end
  end

  // line state
  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (cleanVictim) begin
        dirtyBits[reqIndex] <= 1'b0; // victim taken by memory
      end
      if (storeEn) begin
        dirtyBits[reqIndex] <= 1'b1;
      end
      if (memDataValid) begin
        validBits[memIndex] <= 1'b1;
        dirtyBits[memIndex] <= 1'b0; // refill lands clean
      end
    end
  end

  // tags and data
  always_ff @(posedge clkIn) begin
    if (memDataValid) begin
      tagMem[memIndex]  <= memTag;
      dataMem[memIndex] <= memDataIn;
    end else if (storeEn) begin
      dataMem[reqIndex] <= mergedLine;
    end
  end

endmodule

`default_nettype wire

//--- src/dataCache.sv
`timescale 1ns/1ns
`default_nettype none

module dataCache (
  input  logic                    clkIn,
  input  logic                    resetIn,
  input  dataCachePkg::accessT    accessType,
  input  logic                    readWriteIn,  // 1 for load
  input  dataCachePkg::wordT      dataAddrIn,
  input  dataCachePkg::wordT      dataIn,
  output logic                    dataOutValid,
  output dataCachePkg::wordT      dataOut,
  output logic                    dataWriteSuc,
  input  logic                    memDataValid,
  input  dataCachePkg::blockAddrT memAddr,
  input  dataCachePkg::lineT      memDataIn,
  input  logic                    acceptWrite,
  output logic                    miss,
  output dataCachePkg::blockAddrT missAddr,
  output logic                    readWriteOut, // 0 while a write-back is offered
  output dataCachePkg::blockAddrT memAddrOut,
  output dataCachePkg::lineT      memOut
);

  import dataCachePkg::*;

  // held request
  logic   pending;
  accessT reqAccess;
  logic   reqRead;
  wordT   reqAddr;
  wordT   reqData;

  logic served;
  logic hit;
  lineT hitLine;

  // victim path
  logic victimDirty;
  tagT  victimTag;
  lineT victimLine;
  logic cleanVictim;
  logic evictVictim;

  requestLatch latch (
    .clkIn, .resetIn, .accessType, .readWriteIn, .dataAddrIn, .dataIn,
    .served, .pending, .reqAccess, .reqRead, .reqAddr, .reqData
  );

  cacheArray array (
    .clkIn, .resetIn, .pending, .reqAccess, .reqRead, .reqAddr, .reqData,
    .served, .memDataValid, .memAddr, .memDataIn, .cleanVictim, .evictVictim,
    .hit, .hitLine, .victimDirty, .victimTag, .victimLine
  );

  responseStage response (
    .clkIn, .resetIn, .pending, .reqAccess, .reqRead, .reqAddr, .hit, .hitLine,
    .served, .dataOutValid, .dataOut, .dataWriteSuc
  );

  missControl control (
    .clkIn, .resetIn, .pending, .hit, .reqAddr, .victimDirty, .victimTag,
    .victimLine, .acceptWrite, .memDataValid, .miss, .missAddr, .readWriteOut,
    .memAddrOut, .memOut, .cleanVictim, .evictVictim
  );

endmodule

`default_nettype wire

//--- src/dataCachePkg.sv
`default_nettype none

package dataCachePkg;

  // block geometry
  localparam int BLOCK_WIDTH = 4;
  localparam int BLOCK_BYTES = 2 ** BLOCK_WIDTH;
  localparam int LINE_BITS   = BLOCK_BYTES * 8;

  // 32 lines, direct mapped
  localparam int INDEX_WIDTH = 5;
  localparam int LINES       = 2 ** INDEX_WIDTH;
  localparam int TAG_WIDTH   = 32 - INDEX_WIDTH - BLOCK_WIDTH;

  typedef logic [1:0] accessT;

  // access size codes from the load/store unit
  localparam accessT ACCESS_NONE = 2'd0;
  localparam accessT ACCESS_BYTE = 2'd1;
  localparam accessT ACCESS_HALF = 2'd2;
  localparam accessT ACCESS_WORD = 2'd3;

  typedef logic [BLOCK_WIDTH-1:0]           offsetT;
  typedef logic [INDEX_WIDTH-1:0]           indexT;
  typedef logic [TAG_WIDTH-1:0]             tagT;
  typedef logic [TAG_WIDTH+INDEX_WIDTH-1:0] blockAddrT; // tag then index
  typedef logic [LINE_BITS-1:0]             lineT;
  typedef logic [31:0]                      wordT;

endpackage

`default_nettype wire

//--- src/missControl.sv
`timescale 1ns/1ns
`default_nettype none

module missControl (
  input  logic                    clkIn,
  input  logic                    resetIn,
  input  logic                    pending,
  input  logic                    hit,
  input  dataCachePkg::wordT      reqAddr,
  input  logic                    victimDirty,
  input  dataCachePkg::tagT       victimTag,
  input  dataCachePkg::lineT      victimLine,
  input  logic                    acceptWrite,
  input  logic                    memDataValid,
  output logic                    miss,
  output dataCachePkg::blockAddrT missAddr,
  output logic                    readWriteOut,
  output dataCachePkg::blockAddrT memAddrOut,
  output dataCachePkg::lineT      memOut,
  output logic                    cleanVictim,
  output logic                    evictVictim
);

  import dataCachePkg::*;

  typedef enum logic [1:0] {
    idle,
    writeBack,
    fetch
  } stateT;

  stateT     state;
  indexT     reqIndex;
  blockAddrT reqBlock;
  logic      missing;

  assign reqBlock = reqAddr[31:BLOCK_WIDTH];
  assign reqIndex = reqAddr[BLOCK_WIDTH +: INDEX_WIDTH];
  assign missing  = pending && !hit;

  assign cleanVictim = (state == writeBack) && acceptWrite;
  assign evictVictim = (state == fetch);

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      state        <= idle;
      miss         <= 1'b0;
      readWriteOut <= 1'b1;
    end else begin
      case (state)
        idle: begin
          if (missing && victimDirty) begin
            state        <= writeBack;
            readWriteOut <= 1'b0; // offer the old block first
          end else if (missing) begin
            state <= fetch;
            miss  <= 1'b1;
          end
        end
        writeBack: begin
          if (acceptWrite) begin
            state        <= fetch;
            readWriteOut <= 1'b1;
            miss         <= 1'b1;
          end
        end
        fetch: begin
          if (memDataValid) begin
            state <= idle;
            miss  <= 1'b0; // refill lands this edge
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // addresses and victim data captured once per miss
  always_ff @(posedge clkIn) begin
    if (state == idle && missing) begin
      missAddr   <= reqBlock;
      memAddrOut <= {victimTag, reqIndex};
      memOut     <= victimLine;
    end
  end

endmodule

`default_nettype wire

//--- src/requestLatch.sv
`timescale 1ns/1ns
`default_nettype none

module requestLatch (
  input  logic                 clkIn,
  input  logic                 resetIn,
  input  dataCachePkg::accessT accessType,
  input  logic                 readWriteIn,
  input  dataCachePkg::wordT   dataAddrIn,
  input  dataCachePkg::wordT   dataIn,
  input  logic                 served,
  output logic                 pending,
  output dataCachePkg::accessT reqAccess,
  output logic                 reqRead,
  output dataCachePkg::wordT   reqAddr,
  output dataCachePkg::wordT   reqData
);

  import dataCachePkg::*;

  logic accept;

  // new requests only when idle, others dropped
  assign accept = !pending && (accessType != ACCESS_NONE);

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (served) begin
      pending <= 1'b0; // drops the edge after the hit
    end
  end

  // request payload, held while pending
  always_ff @(posedge clkIn) begin
    if (accept) begin
      reqAccess <= accessType;
      reqRead   <= readWriteIn;
      reqAddr   <= dataAddrIn;
      reqData   <= dataIn;
    end
  end

endmodule

`default_nettype wire

//--- src/responseStage.sv
`timescale 1ns/1ns
`default_nettype none

module responseStage (
  input  logic                 clkIn,
  input  logic                 resetIn,
  input  logic                 pending,
  input  dataCachePkg::accessT reqAccess,
  input  logic                 reqRead,
  input  dataCachePkg::wordT   reqAddr,
  input  logic                 hit,
  input  dataCachePkg::lineT   hitLine,
  output logic                 served,
  output logic                 dataOutValid,
  output dataCachePkg::wordT   dataOut,
  output logic                 dataWriteSuc
);

  import dataCachePkg::*;

  offsetT offset;
  lineT   shifted;
  wordT   loadData;

  assign served = pending && hit;

  assign offset  = reqAddr[BLOCK_WIDTH-1:0];
  assign shifted = hitLine >> {offset, 3'b000}; // addressed byte to bit 0

  // zero extend by size
  always_comb begin
    case (reqAccess)
      ACCESS_BYTE: loadData = {24'b0, shifted[7:0]};
      ACCESS_HALF: loadData = {16'b0, shifted[15:0]};
      ACCESS_WORD: loadData = shifted[31:0];
      default:     loadData = '0;
    endcase
  end

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      dataOutValid <= 1'b0;
      dataWriteSuc <= 1'b0;
    end else begin
      dataOutValid <= served && reqRead;  // one cycle per hit
      dataWriteSuc <= served && !reqRead;
    end
  end

  always_ff @(posedge clkIn) begin
    if (served && reqRead) begin
      dataOut <= loadData;
    end
  end

endmodule

`default_nettype wire
